/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ras_predictor
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

/* branch_decode.sv */
`default_nettype none

module branch_decode
  import ras_pkg::*;
#(
  parameter int PC_W = 32
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             fetch_valid,
  input  wire logic             fetch_thread,
  input  wire logic [PC_W-1:0]  fetch_pc,
  input  wire instr_word_u      fetch_instr,
  output logic                  dec_valid,
  output op_kind_e              dec_kind,
  output logic                  dec_thread,
  output logic [PC_W-1:0]       dec_pc,
  output logic [PC_W-1:0]       dec_link,
  output logic [PC_W-1:0]       dec_target
);

  logic            is_call;
  logic            is_ret;
  op_kind_e        kind_next;
  logic [PC_W-1:0] link_next;
  logic [PC_W-1:0] target_next;

  // Opcode is read from the call view, the source register from the return view.
  assign is_call = fetch_instr.call.opcode == CALL_OPCODE;
  assign is_ret  = (fetch_instr.ret.opcode == RET_OPCODE) &&
                   (fetch_instr.ret.src_reg == LINK_REG);

  always_comb begin
    if (is_call) begin
      kind_next = op_call;
    end else if (is_ret) begin
      kind_next = op_ret;
    end else begin
      kind_next = op_other;
    end
  end

  // Link address skips the call itself.
  assign link_next   = fetch_pc + (fetch_instr.call.short_link ? PC_W'(2) : PC_W'(4));
  assign target_next = fetch_pc + PC_W'($signed(fetch_instr.call.offset));

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
      dec_kind  <= op_other;
    end else begin
      dec_valid <= fetch_valid;
      if (fetch_valid) begin
        dec_kind <= kind_next;
      end
    end
  end

  // Payload fields.
  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      dec_thread <= fetch_thread;
      dec_pc     <= fetch_pc;
      dec_link   <= link_next;
      dec_target <= target_next;
    end
  end

endmodule

`default_nettype wire

/* next_pc_select.sv */
`default_nettype none

module next_pc_select
  import ras_pkg::*;
#(
  parameter int PC_W = 32
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             dec_valid,
  input  wire op_kind_e         dec_kind,
  input  wire logic             dec_thread,
  input  wire logic [PC_W-1:0]  dec_pc,
  input  wire logic [PC_W-1:0]  dec_target,
  input  wire logic [PC_W-1:0]  ret_addr,
  output logic                  predict_valid,
  output logic                  predict_thread,
  output logic [PC_W-1:0]       predict_pc
);

  // Decode fields held one cycle to line up with ret_addr.
  logic            s1_valid;
  op_kind_e        s1_kind;
  logic            s1_thread;
  logic [PC_W-1:0] s1_pc;
  logic [PC_W-1:0] s1_target;
  logic [PC_W-1:0] next_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      s1_kind   <= dec_kind;
      s1_thread <= dec_thread;
      s1_pc     <= dec_pc;
      s1_target <= dec_target;
    end
  end

  always_comb begin
    case (s1_kind)
      op_ret:  next_pc = ret_addr;
      op_call: next_pc = s1_target;
      default: next_pc = s1_pc + PC_W'(4);
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      predict_valid <= 1'b0;
    end else begin
      predict_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      predict_thread <= s1_thread;
      predict_pc     <= next_pc;
    end
  end

endmodule

`default_nettype wire

/* ras_assertions.sv */
`default_nettype none

module ras_assertions #(
  parameter int STACK_AW = 4
) (
  input wire logic                clk,
  input wire logic                rst,
  input wire logic                flush,
  input wire logic                flush_thread,
  input wire logic                do_push,
  input wire logic                do_pop,
  input wire logic                wr_valid,
  input wire logic [STACK_AW-1:0] rd_ptr_0,
  input wire logic [STACK_AW-1:0] rd_ptr_1
);

  int fail_count = 0;

  wr_empty_after_reset: assert property (@(posedge clk) rst |=> !wr_valid)
    else begin
      $error("Write register holds data after reset.");
      fail_count++;
    end

  single_op: assert property (@(posedge clk) disable iff (rst) !(do_push && do_pop))
    else begin
      $error("Push and pop in the same op.");
      fail_count++;
    end

  // Flushed read pointer returns to the last entry.
  flush_ptr_0: assert property (@(posedge clk) disable iff (rst)
    (flush && !flush_thread) |=> (rd_ptr_0 == '1))
    else begin
      $error("Thread 0 read pointer not at the last entry after flush.");
      fail_count++;
    end

  flush_ptr_1: assert property (@(posedge clk) disable iff (rst)
    (flush && flush_thread) |=> (rd_ptr_1 == '1))
    else begin
      $error("Thread 1 read pointer not at the last entry after flush.");
      fail_count++;
    end

endmodule

bind ret_stack ras_assertions #(
  .STACK_AW (STACK_AW)
) i_ras_assertions (
  .clk          (clk),
  .rst          (rst),
  .flush        (flush),
  .flush_thread (flush_thread),
  .do_push      (do_push),
  .do_pop       (do_pop),
  .wr_valid     (wr_valid),
  .rd_ptr_0     (rd_ptr[0]),
  .rd_ptr_1     (rd_ptr[1])
);

`default_nettype wire

/* ras_checker.sv */
`default_nettype none

module ras_checker
  import ras_pkg::*;
#(
  parameter int PC_W = 32
) (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            fetch_valid,
  input  wire logic            fetch_thread,
  input  wire logic [PC_W-1:0] fetch_pc,
  input  wire instr_word_u     fetch_instr,
  input  wire logic            flush,
  input  wire logic            flush_thread,
  input  wire logic            predict_valid,
  input  wire logic            predict_thread,
  input  wire logic [PC_W-1:0] predict_pc,
  output int                   check_count,
  output int                   error_count,
  output int                   pending
);

  // Each thread's model stack holds 16 entries, and top points at the newest one.
  logic [PC_W-1:0] model_mem     [2][16];
  logic            model_written [2][16];
  logic [3:0]      model_top     [2];

  // Expected predictions in fetch order.
  int              exp_due    [$];
  logic            exp_thread [$];
  logic [PC_W-1:0] exp_pc     [$];
  logic            exp_check  [$];

  int cycle     = 0;
  int checks    = 0;
  int errors    = 0;
  int in_flight = 0;

  assign check_count = checks;
  assign error_count = errors;
  assign pending     = in_flight;

  task automatic clear_thread(input logic t);
    for (int i = 0; i < 16; i++) begin
      model_written[t][i] = 1'b0;
    end
    model_top[t] = 4'hf;
  endtask

  task automatic model_fetch();
    logic            t;
    logic [PC_W-1:0] expected;
    logic            checked;
    t        = fetch_thread;
    expected = fetch_pc + PC_W'(4);
    checked  = 1'b1;
    if (fetch_instr.call.opcode == CALL_OPCODE) begin
      expected = fetch_pc + {{(PC_W-25){fetch_instr.call.offset[24]}}, fetch_instr.call.offset};
      model_top[t] = model_top[t] + 4'd1;
      // A short call is two bytes shorter than a full one.
      model_mem[t][model_top[t]] =
        fetch_pc + PC_W'(4) - PC_W'({fetch_instr.call.short_link, 1'b0});
      model_written[t][model_top[t]] = 1'b1;
    end else if (fetch_instr.ret.opcode == RET_OPCODE && fetch_instr.ret.src_reg == LINK_REG) begin
      // Entries never written since reset or flush hold unknown data.
      expected     = model_mem[t][model_top[t]];
      checked      = model_written[t][model_top[t]];
      model_top[t] = model_top[t] - 4'd1;
    end
    exp_due.push_back(cycle + 3);
    exp_thread.push_back(t);
    exp_pc.push_back(expected);
    exp_check.push_back(checked);
  endtask

  task automatic compare_output();
    if (exp_due.size() != 0 && exp_due[0] == cycle) begin
      if (!predict_valid) begin
        errors++;
        $display("Missing prediction at time %0t, three cycles after a fetch", $time);
      end else begin
        checks++;
        if (predict_thread !== exp_thread[0] ||
            (exp_check[0] && predict_pc !== exp_pc[0])) begin
          errors++;
          $display("[FAIL] %0t: thread %0d pc %h, expected thread %0d pc %h",
                   $time, predict_thread, predict_pc, exp_thread[0], exp_pc[0]);
        end
      end
      void'(exp_due.pop_front());
      void'(exp_thread.pop_front());
      void'(exp_pc.pop_front());
      void'(exp_check.pop_front());
    end else if (predict_valid) begin
      errors++;
      $display("Unexpected prediction at time %0t with no fetch three cycles earlier", $time);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      clear_thread(1'b0);
      clear_thread(1'b1);
      exp_due.delete();
      exp_thread.delete();
      exp_pc.delete();
      exp_check.delete();
      cycle = 0;
    end else begin
      cycle++;
      compare_output();
      // The stack sees a flush one cycle before an op fetched alongside it.
      if (flush) begin
        clear_thread(flush_thread);
      end
      if (fetch_valid) begin
        model_fetch();
      end
    end
    in_flight = exp_due.size();
  end

endmodule

`default_nettype wire

/* ras_pkg.sv */
`default_nettype none

package ras_pkg;

  // ==========================================================
  // Opcodes and register numbers
  // ==========================================================

  // Major opcode of a call with a pc-relative target.
  localparam logic [5:0] CALL_OPCODE = 6'h2a;

  // Major opcode of a register-indirect return.
  localparam logic [5:0] RET_OPCODE = 6'h2b;

  // Only returns through this register use the stack.
  localparam logic [4:0] LINK_REG = 5'd31;

  // ==========================================================
  // Decoded operation kind
  // ==========================================================

  typedef enum logic [1:0] {
    op_other = 2'd0,
    op_call  = 2'd1,
    op_ret   = 2'd2
  } op_kind_e;

  // ==========================================================
  // Instruction word
  // ==========================================================

  // The opcode sits in the same bits in both views.
  typedef union packed {
    struct packed {
      logic [5:0]  opcode;
      // Set for a 2-byte call, clear for a 4-byte call.
      logic        short_link;
      logic [24:0] offset;
    } call;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  src_reg;
      logic [20:0] unused;
    } ret;
  } instr_word_u;

endpackage

`default_nettype wire

/* ras_predictor.sv */
`default_nettype none

module ras_predictor
  import ras_pkg::*;
#(
  parameter int PC_W     = 32,
  parameter int STACK_AW = 4
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             fetch_valid,
  input  wire logic             fetch_thread,
  input  wire logic [PC_W-1:0]  fetch_pc,
  input  wire instr_word_u      fetch_instr,
  input  wire logic             flush,
  input  wire logic             flush_thread,
  output logic                  predict_valid,
  output logic                  predict_thread,
  output logic [PC_W-1:0]       predict_pc
);

  logic            dec_valid;
  op_kind_e        dec_kind;
  logic            dec_thread;
  logic [PC_W-1:0] dec_pc;
  logic [PC_W-1:0] dec_link;
  logic [PC_W-1:0] dec_target;
  logic [PC_W-1:0] ret_addr;

  // ==========================================================
  // Decode, stack and select
  // ==========================================================

  branch_decode #(
    .PC_W (PC_W)
  ) i_decode (
    .clk          (clk),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .fetch_thread (fetch_thread),
    .fetch_pc     (fetch_pc),
    .fetch_instr  (fetch_instr),
    .dec_valid    (dec_valid),
    .dec_kind     (dec_kind),
    .dec_thread   (dec_thread),
    .dec_pc       (dec_pc),
    .dec_link     (dec_link),
    .dec_target   (dec_target)
  );

  ret_stack #(
    .PC_W     (PC_W),
    .STACK_AW (STACK_AW)
  ) i_stack (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .flush_thread (flush_thread),
    .op_valid     (dec_valid),
    .op_kind      (dec_kind),
    .op_thread    (dec_thread),
    .push_data    (dec_link),
    .ret_addr     (ret_addr)
  );

  next_pc_select #(
    .PC_W (PC_W)
  ) i_select (
    .clk            (clk),
    .rst            (rst),
    .dec_valid      (dec_valid),
    .dec_kind       (dec_kind),
    .dec_thread     (dec_thread),
    .dec_pc         (dec_pc),
    .dec_target     (dec_target),
    .ret_addr       (ret_addr),
    .predict_valid  (predict_valid),
    .predict_thread (predict_thread),
    .predict_pc     (predict_pc)
  );

endmodule

`default_nettype wire

/* ret_stack.sv */
`default_nettype none

module ret_stack
  import ras_pkg::*;
#(
  parameter int PC_W     = 32,
  parameter int STACK_AW = 4
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             flush,
  input  wire logic             flush_thread,
  input  wire logic             op_valid,
  input  wire op_kind_e         op_kind,
  input  wire logic             op_thread,
  input  wire logic [PC_W-1:0]  push_data,
  output logic [PC_W-1:0]       ret_addr
);

  // ==========================================================
  // Per-thread pointers
  // ==========================================================

  // Read pointer marks the top entry, write pointer the next free one.
  logic [STACK_AW-1:0] rd_ptr [2];
  logic [STACK_AW-1:0] wr_ptr [2];

  logic do_push;
  logic do_pop;

  assign do_push = op_valid && (op_kind == op_call) && !flush;
  assign do_pop  = op_valid && (op_kind == op_ret) && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr[0] <= '1;
      rd_ptr[1] <= '1;
      wr_ptr[0] <= '0;
      wr_ptr[1] <= '0;
    end else if (flush) begin
      rd_ptr[flush_thread] <= '1;
      wr_ptr[flush_thread] <= '0;
    end else if (do_pop) begin
      rd_ptr[op_thread] <= rd_ptr[op_thread] - 1'b1;
      wr_ptr[op_thread] <= wr_ptr[op_thread] - 1'b1;
    end else if (do_push) begin
      // Pointers wrap, so the oldest entry is overwritten on overflow.
      rd_ptr[op_thread] <= rd_ptr[op_thread] + 1'b1;
      wr_ptr[op_thread] <= wr_ptr[op_thread] + 1'b1;
    end
  end

  // ==========================================================
  // Write register
  // ==========================================================

  logic                wr_valid;
  logic                wr_thread;
  logic [STACK_AW-1:0] wr_addr;
  logic [PC_W-1:0]     wr_data;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= do_push;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      wr_thread <= op_thread;
      wr_addr   <= wr_ptr[op_thread];
      wr_data   <= push_data;
    end
  end

  // ==========================================================
  // Storage and bypass
  // ==========================================================

  logic [PC_W-1:0] ram_data;

  ret_stack_ram #(
    .PC_W     (PC_W),
    .STACK_AW (STACK_AW)
  ) i_ram (
    .clk        (clk),
    .rst        (rst),
    .read_en    (do_pop),
    .read_addr  ({op_thread, rd_ptr[op_thread]}),
    .write_addr ({wr_thread, wr_addr}),
    .write_data (wr_data),
    .write_en   (wr_valid),
    .read_data  (ram_data)
  );

  // Pending write data wins over the RAM output.
  assign ret_addr = wr_valid ? wr_data : ram_data;

endmodule

`default_nettype wire

/* ret_stack_ram.sv */
`default_nettype none

module ret_stack_ram #(
  parameter int PC_W     = 32,
  parameter int STACK_AW = 4
) (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                read_en,
  input  wire logic [STACK_AW:0]   read_addr,
  input  wire logic [STACK_AW:0]   write_addr,
  input  wire logic [PC_W-1:0]     write_data,
  input  wire logic                write_en,
  output logic [PC_W-1:0]          read_data
);

  // Top address bit selects the thread.
  logic [PC_W-1:0]   mem [2**(STACK_AW+1)];
  logic [STACK_AW:0] read_addr_q;

  // Read is asynchronous from the registered address.
  assign read_data = mem[read_addr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      read_addr_q <= '0;
    end else if (read_en) begin
      read_addr_q <= read_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

endmodule

`default_nettype wire

/* src.f */
ras_pkg.sv
branch_decode.sv
ret_stack_ram.sv
ret_stack.sv
next_pc_select.sv
ras_predictor.sv
ras_assertions.sv
ras_checker.sv
tb_ras_predictor.sv

/* tb_ras_predictor.sv */
`default_nettype none

module tb_ras_predictor
  import ras_pkg::*;
();

  localparam int PC_W        = 32;
  localparam int STACK_AW    = 4;
  localparam int NUM_RANDOM  = 800;
  localparam int DRAIN_LIMIT = 20;

  logic            clk          = 1'b0;
  logic            rst          = 1'b1;
  logic            fetch_valid  = 1'b0;
  logic            fetch_thread = 1'b0;
  logic [PC_W-1:0] fetch_pc     = '0;
  instr_word_u     fetch_instr  = '0;
  logic            flush        = 1'b0;
  logic            flush_thread = 1'b0;
  logic            predict_valid;
  logic            predict_thread;
  logic [PC_W-1:0] predict_pc;
  int              check_count;
  int              error_count;
  int              pending;
  logic [15:0]     lfsr_state   = 16'd5527;

  always #4 clk = ~clk;

  ras_predictor #(
    .PC_W     (PC_W),
    .STACK_AW (STACK_AW)
  ) i_dut (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_thread   (fetch_thread),
    .fetch_pc       (fetch_pc),
    .fetch_instr    (fetch_instr),
    .flush          (flush),
    .flush_thread   (flush_thread),
    .predict_valid  (predict_valid),
    .predict_thread (predict_thread),
    .predict_pc     (predict_pc)
  );

  ras_checker #(
    .PC_W (PC_W)
  ) i_checker (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_thread   (fetch_thread),
    .fetch_pc       (fetch_pc),
    .fetch_instr    (fetch_instr),
    .flush          (flush),
    .flush_thread   (flush_thread),
    .predict_valid  (predict_valid),
    .predict_thread (predict_thread),
    .predict_pc     (predict_pc),
    .check_count    (check_count),
    .error_count    (error_count),
    .pending        (pending)
  );

  // ==========================================================
  // Random source and word builders
  // ==========================================================

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic instr_word_u call_word(input logic short_link, input logic [24:0] offset);
    instr_word_u word;
    word.call.opcode     = CALL_OPCODE;
    word.call.short_link = short_link;
    word.call.offset     = offset;
    return word;
  endfunction

  function automatic instr_word_u ret_word(input logic [4:0] src_reg);
    instr_word_u word;
    word.ret.opcode  = RET_OPCODE;
    word.ret.src_reg = src_reg;
    word.ret.unused  = '0;
    return word;
  endfunction

  // ==========================================================
  // Drivers
  // ==========================================================

  // Inputs change 1 time unit after the rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
    fetch_valid = 1'b0;
    flush       = 1'b0;
  endtask

  task automatic send_word(input logic thread, input logic [31:0] pc, input instr_word_u word);
    next_cycle();
    fetch_valid  = 1'b1;
    fetch_thread = thread;
    fetch_pc     = pc;
    fetch_instr  = word;
  endtask

  // Two idle cycles keep the flush clear of any op in flight.
  task automatic send_flush(input logic thread);
    next_cycle();
    next_cycle();
    next_cycle();
    flush        = 1'b1;
    flush_thread = thread;
  endtask

  initial begin
    logic [31:0] choice;
    logic [31:0] bits;
    logic [31:0] raw;
    logic [31:0] pc;
    logic        thread;
    instr_word_u word;
    int          waited;
    int          timeouts;
    int          assert_fails;

    timeouts = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Deep nesting on thread 0 wraps its stack, thread 1 sits underneath.
    for (int i = 0; i < 20; i++) begin
      send_word(1'b0, 32'h0000_1000 + 32'(i * 64), call_word(i[0], 25'(i * 8 + 256)));
      if (i % 5 == 0) begin
        send_word(1'b1, 32'h0000_8000 + 32'(i * 64), call_word(1'b0, 25'h1ff_fff0));
      end
    end
    for (int i = 0; i < 20; i++) begin
      send_word(1'b0, 32'h0000_2000, ret_word(LINK_REG));
    end
    for (int i = 0; i < 4; i++) begin
      send_word(1'b1, 32'h0000_9000, ret_word(LINK_REG));
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      take_bits(4, choice);
      take_bits(1, bits);
      thread = bits[0];
      take_bits(20, raw);
      pc = 32'h0040_0000 | {11'd0, raw[19:0], 1'b0};
      if (choice[3:0] <= 4'd4) begin
        take_bits(1, bits);
        take_bits(25, raw);
        send_word(thread, pc, call_word(bits[0], raw[24:0]));
      end else if (choice[3:0] <= 4'd8) begin
        send_word(thread, pc, ret_word(LINK_REG));
      end else if (choice[3:0] == 4'd9) begin
        take_bits(5, bits);
        if (bits[4:0] == LINK_REG) begin
          bits[4:0] = 5'd0;
        end
        send_word(thread, pc, ret_word(bits[4:0]));
      end else if (choice[3:0] <= 4'd11) begin
        take_bits(32, raw);
        word = raw;
        if (word.call.opcode == CALL_OPCODE || word.call.opcode == RET_OPCODE) begin
          word.call.opcode = 6'h00;
        end
        send_word(thread, pc, word);
      end else if (choice[3:0] <= 4'd14) begin
        next_cycle();
      end else begin
        send_flush(thread);
      end
    end

    // Drain the pipeline.
    next_cycle();
    waited = 0;
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("Timeout: %0d predictions still outstanding after the drain", pending);
    end

    assert_fails = i_dut.i_stack.i_ras_assertions.fail_count;
    $display("Closing: %0d checks, %0d errors, %0d assertion failures, %0d timeouts",
             check_count, error_count, assert_fails, timeouts);
    if (error_count == 0 && assert_fails == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
